// File: wbBusDefines_defines.svh
`ifndef WB_BUS_DEFINES_SVH
`define WB_BUS_DEFINES_SVH

// Number of bus masters, a power of two so the rotation wraps
`define WB_PORT_COUNT 4
// Bits needed to name one master
`define WB_PORT_ADDR_W 2

// Word address and data widths
`define WB_ADDR_W 8
`define WB_DATA_W 32

// RAM words, anything at or above answers with err
`define WB_MEM_DEPTH 64

`endif

// File: wbBusPkg.sv
`include "wbBusDefines_defines.svh"

package wbBusPkg;

    // Index of one master
    typedef logic [`WB_PORT_ADDR_W-1:0] portIdT;

    // One bit per master
    typedef logic [`WB_PORT_COUNT-1:0] portVecT;

    // Word address on the bus
    typedef logic [`WB_ADDR_W-1:0] addrT;

    // Data word on the bus
    typedef logic [`WB_DATA_W-1:0] dataT;

endpackage

// File: portPriority.sv
`include "wbBusDefines_defines.svh"

module portPriority
    import wbBusPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  portVecT cyc,
    output portIdT  owner,
    output logic    ownerValid
);

    // Port that currently has top priority
    portIdT prioIdx;

    // Request vector rotated so prioIdx lands on bit 0
    logic [2*`WB_PORT_COUNT-1:0] doubledReq;
    logic [2*`WB_PORT_COUNT-1:0] shiftedWide;
    portVecT shiftedReq;

    // Lowest set bit of the rotated vector, one-hot
    portVecT isolatedBit;

    // Per output bit, which one-hot positions set it
    portVecT bitMask [`WB_PORT_ADDR_W];
    portIdT scanResult;

    // Winning port in absolute numbering
    portIdT winner;
    portIdT nextPrio;

    // Bus can be handed over this cycle
    logic busFree;
    logic anyReq;

    assign doubledReq  = {cyc, cyc};
    assign shiftedWide = doubledReq >> prioIdx;
    assign shiftedReq  = shiftedWide[`WB_PORT_COUNT-1:0];

    // Two's complement trick keeps only the lowest one
    assign isolatedBit = shiftedReq & -shiftedReq;

    // Bit-mask scan, one OR-reduction per index bit
    for (genvar m = 0; m < `WB_PORT_ADDR_W; m++) begin : genMaskScan
        for (genvar b = 0; b < `WB_PORT_COUNT; b++) begin : genMaskBit
            // Set where bit m of index b is one
            assign bitMask[m][b] = 1'((b >> m) & 1);
        end
        assign scanResult[m] = |(isolatedBit & bitMask[m]);
    end

    // Undo the rotation, wraps since port count is a power of two
    assign winner   = portIdT'(scanResult + prioIdx);
    assign nextPrio = portIdT'(winner + 1'b1);

    assign anyReq  = |cyc;
    // No owner, or the owner just dropped cyc
    assign busFree = !ownerValid || !cyc[owner];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ownerValid <= 1'b0;
            owner      <= '0;
            prioIdx    <= '0;
        end else if (busFree) begin
            ownerValid <= anyReq;
            if (anyReq) begin
                owner   <= winner;
                // Winner drops to last place
                prioIdx <= nextPrio;
            end
        end
    end

    // Grant is held for the owner's whole bus cycle
    ownerHeld : assert property (
        @(posedge clk) disable iff (!arstN)
        (ownerValid && cyc[owner]) |=> (ownerValid && owner == $past(owner))
    );

    // A grant always answers a request seen the cycle before
    grantNeedsReq : assert property (
        @(posedge clk) disable iff (!arstN)
        $rose(ownerValid) |-> $past(|cyc)
    );

endmodule

// File: busMux.sv
`include "wbBusDefines_defines.svh"

module busMux
    import wbBusPkg::*;
(
    input  portIdT  owner,
    input  logic    ownerValid,

    // Master side requests
    input  portVecT mCyc,
    input  portVecT mStb,
    input  portVecT mWe,
    input  addrT    mAddr [`WB_PORT_COUNT],
    input  dataT    mWdata [`WB_PORT_COUNT],

    // Master side responses
    output portVecT mAck,
    output portVecT mErr,

    // Slave side request
    output logic    sCyc,
    output logic    sStb,
    output logic    sWe,
    output addrT    sAddr,
    output dataT    sWdata,

    // Slave side response
    input  logic    sAck,
    input  logic    sErr
);

    // One-hot of the current owner, all zero when idle
    portVecT ownerSel;

    always_comb begin
        ownerSel = '0;
        if (ownerValid) begin
            ownerSel[owner] = 1'b1;
        end
    end

    // Strobes stay low unless somebody owns the bus
    assign sCyc = ownerValid && mCyc[owner];
    assign sStb = ownerValid && mStb[owner];

    // Payload follows the owner index, qualified by the strobes above
    assign sWe    = mWe[owner];
    assign sAddr  = mAddr[owner];
    assign sWdata = mWdata[owner];

    // Responses only reach the owner
    for (genvar p = 0; p < `WB_PORT_COUNT; p++) begin : genSteer
        assign mAck[p] = sAck && ownerSel[p];
        assign mErr[p] = sErr && ownerSel[p];
    end

endmodule

// File: wbRamSlave.sv
`include "wbBusDefines_defines.svh"

module wbRamSlave
    import wbBusPkg::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic cyc,
    input  logic stb,
    input  logic we,
    input  addrT addr,
    input  dataT wdata,
    output dataT rdata,
    output logic ack,
    output logic err
);

    // Word index bits into the RAM
    localparam int MemIdxW = $clog2(`WB_MEM_DEPTH);

    dataT mem [`WB_MEM_DEPTH];

    logic [MemIdxW-1:0] memIdx;
    logic inRange;
    // New transfer seen, previous one already answered
    logic respond;
    logic doAccess;

    assign memIdx  = addr[MemIdxW-1:0];
    assign inRange = addr < `WB_MEM_DEPTH;

    // Response still high means this cycle is the tail of the last transfer
    assign respond  = cyc && stb && !ack && !err;
    assign doAccess = respond && inRange;

    // Single-cycle ack or err
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ack <= 1'b0;
            err <= 1'b0;
        end else begin
            ack <= doAccess;
            err <= respond && !inRange;
        end
    end

    // Write lands on the ack edge
    always_ff @(posedge clk) begin
        if (doAccess && we) begin
            mem[memIdx] <= wdata;
        end
    end

    // Read word registered alongside ack
    always_ff @(posedge clk) begin
        if (doAccess && !we) begin
            rdata <= mem[memIdx];
        end
    end

    // Exactly one kind of response per transfer
    ackErrExclusive : assert property (
        @(posedge clk) disable iff (!arstN)
        !(ack && err)
    );

endmodule

// File: wbSharedBus.sv
`include "wbBusDefines_defines.svh"

module wbSharedBus
    import wbBusPkg::*;
(
    input  logic    clk,
    input  logic    arstN,

    // One entry per master
    input  portVecT cyc,
    input  portVecT stb,
    input  portVecT we,
    input  addrT    addr [`WB_PORT_COUNT],
    input  dataT    wdata [`WB_PORT_COUNT],

    output portVecT ack,
    output portVecT err,
    // Broadcast to every master
    output dataT    rdata
);

    // Current bus owner
    portIdT owner;
    logic   ownerValid;

    // Muxed request into the RAM
    logic sCyc;
    logic sStb;
    logic sWe;
    addrT sAddr;
    dataT sWdata;

    // RAM response before steering
    logic sAck;
    logic sErr;

    portPriority prio0 (
        .clk        (clk),
        .arstN      (arstN),
        .cyc        (cyc),
        .owner      (owner),
        .ownerValid (ownerValid)
    );

    busMux mux0 (
        .owner      (owner),
        .ownerValid (ownerValid),
        .mCyc       (cyc),
        .mStb       (stb),
        .mWe        (we),
        .mAddr      (addr),
        .mWdata     (wdata),
        .mAck       (ack),
        .mErr       (err),
        .sCyc       (sCyc),
        .sStb       (sStb),
        .sWe        (sWe),
        .sAddr      (sAddr),
        .sWdata     (sWdata),
        .sAck       (sAck),
        .sErr       (sErr)
    );

    wbRamSlave ram0 (
        .clk   (clk),
        .arstN (arstN),
        .cyc   (sCyc),
        .stb   (sStb),
        .we    (sWe),
        .addr  (sAddr),
        .wdata (sWdata),
        .rdata (rdata),
        .ack   (sAck),
        .err   (sErr)
    );

endmodule

// File: tbWbSharedBus.sv
`include "wbBusDefines_defines.svh"

module tbWbSharedBus
    import wbBusPkg::*;
();

    // Cycles a master waits for ack or err before giving up
    localparam int WaitLimit = 64;

    logic    clk;
    logic    arstN;
    portVecT cyc;
    portVecT stb;
    portVecT we;
    addrT    addr [`WB_PORT_COUNT];
    dataT    wdata [`WB_PORT_COUNT];
    portVecT ack;
    portVecT err;
    dataT    rdata;

    // Expected RAM contents
    dataT sbMem [`WB_MEM_DEPTH];
    // Ports in the order their transfers finished
    int   doneOrder [$];
    int   doneCycle [`WB_PORT_COUNT];
    int   dropCycle [`WB_PORT_COUNT];
    int   cycleCnt = 0;
    int   errCount = 0;

    wbSharedBus dut0 (
        .clk   (clk),
        .arstN (arstN),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .err   (err),
        .rdata (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Free-running cycle stamp
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    // Initial RAM word, every address bit shows up
    function automatic dataT fillWord(input addrT a);
        return {8'hA5, a, ~a, a ^ 8'h3C};
    endfunction

    task automatic resetDut();
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        #1 arstN = 1'b1;
    endtask

    // One Wishbone classic transfer from one master
    task automatic transfer(input int port, input logic write, input addrT wordAddr,
                            input dataT wordData, input logic expErr, input int holdCyc,
                            output int latency);
        int   waitCnt;
        int   idx;
        logic gotAck;
        logic gotErr;
        idx     = wordAddr % `WB_MEM_DEPTH;
        waitCnt = 0;
        gotAck  = 1'b0;
        gotErr  = 1'b0;
        we[port]    = write;
        addr[port]  = wordAddr;
        wdata[port] = wordData;
        cyc[port]   = 1'b1;
        stb[port]   = 1'b1;
        while (!gotAck && !gotErr && waitCnt < WaitLimit) begin
            @(posedge clk);
            #1;
            waitCnt++;
            gotAck = ack[port];
            gotErr = err[port];
            // Only the owner ever sees a response
            assert ($onehot0(ack | err)) else begin
                $display("Error: ack 0x%0h err 0x%0h, more than one bit set", ack, err);
                errCount++;
            end
        end
        latency = waitCnt;
        assert (gotAck || gotErr) else begin
            $display("Port %0d timed out waiting for ack or err", port);
            errCount++;
        end
        if (gotAck || gotErr) begin
            assert (gotErr == expErr) else begin
                $display("Error: err[%0d] got 0x%0h expected 0x%0h", port, gotErr, expErr);
                errCount++;
            end
            assert (gotAck == !expErr) else begin
                $display("Error: ack[%0d] got 0x%0h expected 0x%0h", port, gotAck, !expErr);
                errCount++;
            end
            if (gotAck && write) begin
                sbMem[idx] = wordData;
            end else if (gotAck) begin
                assert (rdata === sbMem[idx]) else begin
                    $display("Error: rdata port %0d got 0x%08h expected 0x%08h",
                             port, rdata, sbMem[idx]);
                    errCount++;
                end
            end
            doneOrder.push_back(port);
            doneCycle[port] = cycleCnt;
        end
        // Keep cyc up with stb low to lock the bus
        stb[port] = 1'b0;
        repeat (holdCyc) begin
            @(posedge clk);
            #1;
        end
        cyc[port] = 1'b0;
        dropCycle[port] = cycleCnt;
        @(posedge clk);
        #1;
    endtask

    task automatic fillRam();
        int lat;
        for (int a = 0; a < `WB_MEM_DEPTH; a++) begin
            transfer(0, 1'b1, addrT'(a), fillWord(addrT'(a)), 1'b0, 0, lat);
        end
    endtask

    task automatic testSingleWriteRead();
        int   lat;
        addrT a;
        a = addrT'($urandom_range(`WB_MEM_DEPTH - 1));
        transfer(0, 1'b1, a, $urandom, 1'b0, 0, lat);
        assert (lat == 2) else begin
            $display("Error: write ack latency got 0x%0h expected 0x2", lat);
            errCount++;
        end
        transfer(0, 1'b0, a, '0, 1'b0, 0, lat);
        assert (lat == 2) else begin
            $display("Error: read ack latency got 0x%0h expected 0x2", lat);
            errCount++;
        end
    endtask

    task automatic testOutOfRange();
        int lat;
        // Low bits alias word 5 if the range check were missing
        transfer(0, 1'b1, 8'hC5, $urandom, 1'b1, 0, lat);
        transfer(1, 1'b0, 8'h40, '0, 1'b1, 0, lat);
        transfer(0, 1'b0, 8'h05, '0, 1'b0, 0, lat);
    endtask

    task automatic testRoundRobin();
        int lat [`WB_PORT_COUNT];
        resetDut();
        doneOrder.delete();
        fork
            transfer(0, 1'b0, 8'h01, '0, 1'b0, 0, lat[0]);
            transfer(1, 1'b1, 8'h02, $urandom, 1'b0, 0, lat[1]);
            transfer(2, 1'b0, 8'h03, '0, 1'b0, 0, lat[2]);
            transfer(3, 1'b1, 8'h04, $urandom, 1'b0, 0, lat[3]);
        join
        assert (doneOrder.size() == `WB_PORT_COUNT) else begin
            $display("Round-robin test finished only %0d transfers", doneOrder.size());
            errCount++;
        end
        for (int i = 0; i < doneOrder.size(); i++) begin
            assert (doneOrder[i] == i) else begin
                $display("Error: ack order slot %0d got 0x%0h expected 0x%0h",
                         i, doneOrder[i], i);
                errCount++;
            end
        end
    endtask

    task automatic testFairness();
        int lat [`WB_PORT_COUNT];
        transfer(1, 1'b0, 8'h10, '0, 1'b0, 0, lat[1]);
        transfer(3, 1'b0, 8'h11, '0, 1'b0, 0, lat[3]);
        doneOrder.delete();
        // Port 3 was last, so port 0 now leads
        fork
            transfer(3, 1'b1, 8'h12, $urandom, 1'b0, 0, lat[3]);
            transfer(0, 1'b1, 8'h13, $urandom, 1'b0, 0, lat[0]);
        join
        assert (doneOrder.size() > 0 && doneOrder[0] == 0) else begin
            $display("Error: first winner got 0x%0h expected 0x0",
                     doneOrder.size() > 0 ? doneOrder[0] : -1);
            errCount++;
        end
    endtask

    task automatic testGrantHold();
        int lat [`WB_PORT_COUNT];
        fork
            transfer(2, 1'b1, 8'h20, $urandom, 1'b0, 5, lat[2]);
            begin
                @(posedge clk);
                #1;
                transfer(1, 1'b0, 8'h20, '0, 1'b0, 0, lat[1]);
            end
        join
        // Waiting master must stay silent while port 2 holds cyc
        assert (doneCycle[1] > dropCycle[2]) else begin
            $display("Port 1 got a response while port 2 still owned the bus");
            errCount++;
        end
    endtask

    task automatic randomTraffic(input int port, input int count);
        int   lat;
        addrT a;
        logic write;
        for (int i = 0; i < count; i++) begin
            a     = addrT'($urandom_range(`WB_MEM_DEPTH - 1));
            write = 1'($urandom_range(1));
            transfer(port, write, a, $urandom, 1'b0, 0, lat);
        end
    endtask

    task automatic testRandomTraffic();
        fork
            randomTraffic(0, 25);
            randomTraffic(1, 25);
            randomTraffic(2, 25);
            randomTraffic(3, 25);
        join
    endtask

    initial begin
        void'($urandom(54526));
        arstN = 1'b0;
        cyc   = '0;
        stb   = '0;
        we    = '0;
        for (int p = 0; p < `WB_PORT_COUNT; p++) begin
            addr[p]  = '0;
            wdata[p] = '0;
        end
        resetDut();
        fillRam();
        testSingleWriteRead();
        testOutOfRange();
        testRoundRobin();
        testFairness();
        testGrantHold();
        testRandomTraffic();
        $display("Errors: %0d", errCount);
        if (errCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
wbBusPkg.sv
portPriority.sv
busMux.sv
wbRamSlave.sv
wbSharedBus.sv
tbWbSharedBus.sv

// File: Bender.yml
package:
  name: wb_shared_bus

sources:
  - include_dirs:
      - .
    files:
      - wbBusPkg.sv
      - portPriority.sv
      - busMux.sv
      - wbRamSlave.sv
      - wbSharedBus.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbWbSharedBus.sv
